/* verilog/pwm_defines.svh */
// ====================
// PWM subsystem constants
// Bus width, register map, identification word,
// read latency and counter width
// ====================
`ifndef PWM_DEFINES_SVH
`define PWM_DEFINES_SVH

// Data and address width of APB and of the simple bus
`define PWM_DATA_W 32

// Width of the period counter and of the period and duty fields
`define PWM_CNT_W 16

// Cycles from a sampled read strobe to read_valid, valid range 1 to 4
`define PWM_READ_LATENCY 2

// Register offsets, decoded on address bits 3:2 with all higher bits zero
`define PWM_OFS_CTRL 32'h0000_0000
`define PWM_OFS_PERIOD 32'h0000_0004
`define PWM_OFS_DUTY 32'h0000_0008
`define PWM_OFS_ID 32'h0000_000C

// Constant identification word, read only
`define PWM_ID_VALUE 32'h5057_4D01

`endif

/* verilog/pwm_pkg.sv */
// ====================
// PWM subsystem types
// APB and simple bus bundles, CTRL word layout
// and the configuration handed to the generator
// ====================
`include "pwm_defines.svh"

package pwm_pkg;

    // Master side of APB, as driven into the slave
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`PWM_DATA_W-1:0] paddr;
        logic [`PWM_DATA_W-1:0] pwdata;
    } apb_req_t;

    // Slave answer on APB
    typedef struct packed {
        logic                   pready;
        logic [`PWM_DATA_W-1:0] prdata;
        logic                   pslverr;
    } apb_rsp_t;

    // Simple bus request, strobes last a single cycle
    typedef struct packed {
        logic [`PWM_DATA_W-1:0] address;
        logic                   read_strobe;
        logic                   write_strobe;
        logic [`PWM_DATA_W-1:0] write_data;
    } sb_req_t;

    // Simple bus read answer, read_valid is a one cycle pulse
    typedef struct packed {
        logic [`PWM_DATA_W-1:0] read_data;
        logic                   read_valid;
    } sb_rsp_t;

    // Field view of the CTRL register
    typedef struct packed {
        logic [`PWM_DATA_W-3:0] reserved;
        logic                   invert;
        logic                   enable;
    } pwm_ctrl_t;

    // The register block keeps the raw word, the generator reads the fields
    typedef union packed {
        logic [`PWM_DATA_W-1:0] raw;
        pwm_ctrl_t              fields;
    } pwm_ctrl_u;

    // Live settings from the register block to the generator
    typedef struct packed {
        pwm_ctrl_u              ctrl;
        logic [`PWM_CNT_W-1:0]  period;
        logic [`PWM_CNT_W-1:0]  duty;
    } pwm_cfg_t;

endpackage

/* verilog/apb_sb_bridge.sv */
// ====================
// APB slave to simple bus bridge
// Turns APB setup cycles into single cycle strobes and
// holds PREADY low until read data comes back
// ====================
`timescale 1ns/1ps
`include "pwm_defines.svh"

module apb_sb_bridge import pwm_pkg::*; (
    input  logic     PCLK,
    input  logic     PRESETn,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output sb_req_t  sb_req,
    input  sb_rsp_t  sb_rsp
);

    // Only one read can be outstanding, so two states are enough
    typedef enum logic {
        IDLE,
        WAIT_READ
    } bridge_state_e;

    bridge_state_e state;

    logic                   pready_q;
    logic [`PWM_DATA_W-1:0] prdata_q;
    logic                   setup_phase;

    // An APB setup cycle is selected but not yet enabled
    assign setup_phase = apb_req.psel && !apb_req.penable;

    // Strobes follow the setup cycle directly, so a write lands
    // in the register block at the edge that ends setup
    always_comb begin
        sb_req = '0;
        if (setup_phase) begin
            sb_req.address = apb_req.paddr;
            if (apb_req.pwrite) begin
                sb_req.write_strobe = 1'b1;
                sb_req.write_data   = apb_req.pwdata;
            end else begin
                sb_req.read_strobe = 1'b1;
            end
        end
    end

    // Read handshake
    // PREADY drops at the end of a read setup and comes back
    // one edge after read_valid, together with the captured data
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            state    <= IDLE;
            pready_q <= 1'b1;
            prdata_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (setup_phase && !apb_req.pwrite) begin
                        state    <= WAIT_READ;
                        pready_q <= 1'b0;
                    end
                end
                WAIT_READ: begin
                    if (sb_rsp.read_valid) begin
                        state    <= IDLE;
                        pready_q <= 1'b1;
                        prdata_q <= sb_rsp.read_data;
                    end
                end
                default: begin
                    state    <= IDLE;
                    pready_q <= 1'b1;
                end
            endcase
        end
    end

    // No error responses are ever produced
    assign apb_rsp.pready  = pready_q;
    assign apb_rsp.prdata  = prdata_q;
    assign apb_rsp.pslverr = 1'b0;

endmodule

/* verilog/pwm_regs.sv */
// ====================
// PWM register block
// CTRL, PERIOD and DUTY storage on the simple bus,
// identification word and a fixed latency read path
// ====================
`timescale 1ns/1ps
`include "pwm_defines.svh"

module pwm_regs import pwm_pkg::*; (
    input  logic     PCLK,
    input  logic     PRESETn,
    input  sb_req_t  sb_req,
    output sb_rsp_t  sb_rsp,
    output pwm_cfg_t cfg
);

    pwm_ctrl_u              ctrl_q;
    logic [`PWM_DATA_W-1:0] period_q;
    logic [`PWM_DATA_W-1:0] duty_q;

    // Word aligned addresses, bits 1:0 are not part of the decode
    logic [`PWM_DATA_W-1:0] wr_addr;
    logic [`PWM_DATA_W-1:0] rd_addr;

    // Sampled read request
    logic                   rd_pend_q;
    logic [`PWM_DATA_W-1:0] rd_addr_q;
    logic [`PWM_DATA_W-1:0] rd_word;

    // Read pipeline, one entry per cycle of latency
    logic [`PWM_READ_LATENCY-1:0] vld_pipe;
    logic [`PWM_DATA_W-1:0]       data_pipe [`PWM_READ_LATENCY];

    assign wr_addr = {sb_req.address[`PWM_DATA_W-1:2], 2'b00};
    assign rd_addr = {rd_addr_q[`PWM_DATA_W-1:2], 2'b00};

    // Register writes take effect at the edge that samples the strobe
    // Unmapped offsets and the ID word silently drop the write
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            ctrl_q.raw <= '0;
            period_q   <= '0;
            duty_q     <= '0;
        end else if (sb_req.write_strobe) begin
            case (wr_addr)
                `PWM_OFS_CTRL:   ctrl_q.raw <= sb_req.write_data;
                `PWM_OFS_PERIOD: period_q   <= sb_req.write_data;
                `PWM_OFS_DUTY:   duty_q     <= sb_req.write_data;
                default: ;
            endcase
        end
    end

    // First stage of the read path holds the request itself
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= sb_req.read_strobe;
        end
    end

    always_ff @(posedge PCLK) begin
        if (sb_req.read_strobe) begin
            rd_addr_q <= sb_req.address;
        end
    end

    // Word selection for the captured address
    // Anything outside the map reads back as zero
    always_comb begin
        case (rd_addr)
            `PWM_OFS_CTRL:   rd_word = ctrl_q.raw;
            `PWM_OFS_PERIOD: rd_word = period_q;
            `PWM_OFS_DUTY:   rd_word = duty_q;
            `PWM_OFS_ID:     rd_word = `PWM_ID_VALUE;
            default:         rd_word = '0;
        endcase
    end

    // Shift pipeline for the valid bit
    // Its depth alone sets the read latency
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd_pend_q;
            for (int i = 1; i < `PWM_READ_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    // Data moves alongside the valid bit
    always_ff @(posedge PCLK) begin
        data_pipe[0] <= rd_word;
        for (int i = 1; i < `PWM_READ_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign sb_rsp.read_valid = vld_pipe[`PWM_READ_LATENCY-1];
    assign sb_rsp.read_data  = data_pipe[`PWM_READ_LATENCY-1];

    // Generator settings, only the low bits of period and duty matter
    assign cfg.ctrl   = ctrl_q;
    assign cfg.period = period_q[`PWM_CNT_W-1:0];
    assign cfg.duty   = duty_q[`PWM_CNT_W-1:0];

endmodule

/* verilog/pwm_generator.sv */
// ====================
// PWM generator
// Period counter with shadowed period and duty,
// registered PWM output and start of period pulse
// ====================
`timescale 1ns/1ps
`include "pwm_defines.svh"

module pwm_generator import pwm_pkg::*; (
    input  logic     PCLK,
    input  logic     PRESETn,
    input  pwm_cfg_t cfg,
    output logic     pwm_out,
    output logic     period_start
);

    logic                  enable;
    logic                  invert;

    // Shadow copies, only refreshed at a period boundary
    logic [`PWM_CNT_W-1:0] shadow_period;
    logic [`PWM_CNT_W-1:0] shadow_duty;
    logic [`PWM_CNT_W-1:0] cnt;

    logic [`PWM_CNT_W-1:0] last_cnt;
    logic                  period_end;
    logic                  reload;

    assign enable = cfg.ctrl.fields.enable;
    assign invert = cfg.ctrl.fields.invert;

    // A period of zero behaves like a period of one
    assign last_cnt   = (shadow_period == '0) ? '0 : shadow_period - 1'b1;
    assign period_end = (cnt == last_cnt);

    // Reloading only here means a new setting never cuts a period short
    assign reload = !enable || period_end;

    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            shadow_period <= '0;
            shadow_duty   <= '0;
        end else if (reload) begin
            shadow_period <= cfg.period;
            shadow_duty   <= cfg.duty;
        end
    end

    // Counter runs 0 to period-1 and parks at zero while disabled
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            cnt <= '0;
        end else if (!enable || period_end) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Outputs are registered from the current count so they never glitch
    // They lag the counter by one cycle, which keeps the two in step
    always_ff @(posedge PCLK) begin
        if (!PRESETn) begin
            pwm_out      <= 1'b0;
            period_start <= 1'b0;
        end else if (enable) begin
            pwm_out      <= (cnt < shadow_duty) ^ invert;
            period_start <= (cnt == '0);
        end else begin
            // Idle level follows the polarity setting
            pwm_out      <= invert;
            period_start <= 1'b0;
        end
    end

endmodule

/* verilog/pwm_apb_top.sv */
// ====================
// APB controlled PWM channel
// Bridge, register block and generator
// ====================
`timescale 1ns/1ps

module pwm_apb_top import pwm_pkg::*; (
    input  logic     PCLK,
    input  logic     PRESETn,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output logic     pwm_out,
    output logic     period_start
);

    sb_req_t  sb_req;
    sb_rsp_t  sb_rsp;
    pwm_cfg_t cfg;

    // APB front end
    apb_sb_bridge u_bridge (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .sb_req  (sb_req),
        .sb_rsp  (sb_rsp)
    );

    // Register map on the simple bus
    pwm_regs u_regs (
        .PCLK    (PCLK),
        .PRESETn (PRESETn),
        .sb_req  (sb_req),
        .sb_rsp  (sb_rsp),
        .cfg     (cfg)
    );

    // Output stage
    pwm_generator u_gen (
        .PCLK         (PCLK),
        .PRESETn      (PRESETn),
        .cfg          (cfg),
        .pwm_out      (pwm_out),
        .period_start (period_start)
    );

endmodule

/* verification/pwm_apb_assert.sv */
// ====================
// APB bridge protocol checks
// Strobe exclusivity, bounded PREADY stall
// and read_valid only during a pending read
// ====================
`timescale 1ns/1ps
`include "pwm_defines.svh"

module pwm_apb_assert import pwm_pkg::*; (
    input logic     PCLK,
    input logic     PRESETn,
    input apb_rsp_t apb_rsp,
    input sb_req_t  sb_req,
    input sb_rsp_t  sb_rsp
);

    int unsigned low_cycles;
    int unsigned fail_count;

    initial fail_count = 0;

    // Length of the current PREADY stall in cycles
    always_ff @(posedge PCLK) begin
        if (!PRESETn || apb_rsp.pready) begin
            low_cycles <= 0;
        end else begin
            low_cycles <= low_cycles + 1;
        end
    end

    // A setup cycle is either a read or a write, never both
    strobe_excl: assert property (@(posedge PCLK) disable iff (!PRESETn)
        !(sb_req.read_strobe && sb_req.write_strobe))
        else begin
            $error("read and write strobes high together");
            fail_count++;
        end

    // The read path has a fixed latency, so the stall is bounded
    stall_bound: assert property (@(posedge PCLK) disable iff (!PRESETn)
        low_cycles <= `PWM_READ_LATENCY + 1)
        else begin
            $error("PREADY low for too long");
            fail_count++;
        end

    // PREADY is low exactly while the bridge waits for read data
    valid_in_wait: assert property (@(posedge PCLK) disable iff (!PRESETn)
        sb_rsp.read_valid |-> !apb_rsp.pready)
        else begin
            $error("read_valid while the bridge is idle");
            fail_count++;
        end

endmodule

bind apb_sb_bridge pwm_apb_assert u_assert (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .apb_rsp (apb_rsp),
    .sb_req  (sb_req),
    .sb_rsp  (sb_rsp)
);

/* verification/tb_pwm_apb.sv */
// ====================
// Testbench for the APB controlled PWM channel
// LFSR stimulus against a register model and
// measured duty cycles on the PWM output
// ====================
`timescale 1ns/1ps
`include "pwm_defines.svh"

module tb_pwm_apb import pwm_pkg::*; ();

    // Run length budget from the transfers and the measured PWM cycles
    localparam int N_XFERS     = 80 + 18 + 2 * 8 * 4 + 2;
    localparam int PWM_CYCLES  = 2 * 8 * 3 * (40 + 1) + 2 * 50 + 2 * 5;
    localparam int CYCLE_LIMIT = N_XFERS * (`PWM_READ_LATENCY + 3) + PWM_CYCLES + 200;

    logic     PCLK;
    logic     PRESETn;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     pwm_out;
    logic     period_start;

    logic [31:0] lfsr_state;
    // Expected contents of CTRL, PERIOD and DUTY
    logic [31:0] model_regs [3];
    int          checks;
    int          errors;
    int          test_base;
    int          cycles;

    pwm_apb_top uut (
        .PCLK         (PCLK),
        .PRESETn      (PRESETn),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .pwm_out      (pwm_out),
        .period_start (period_start)
    );

    initial begin
        PCLK = 1'b0;
        forever #10 PCLK = ~PCLK;
    end

    // The watchdog ends the run if the test sequence stalls
    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge PCLK);
            cycles++;
        end
        $display("Timeout after %0d cycles, the test sequence never completed", cycles);
        $display("Test FAILED");
        $finish;
    end

    // Taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Register map as seen from APB where anything else reads zero
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        case (addr)
            `PWM_OFS_CTRL:   return model_regs[0];
            `PWM_OFS_PERIOD: return model_regs[1];
            `PWM_OFS_DUTY:   return model_regs[2];
            `PWM_OFS_ID:     return `PWM_ID_VALUE;
            default:         return '0;
        endcase
    endfunction

    task automatic apply_reset();
        PRESETn = 1'b0;
        repeat (5) @(posedge PCLK);
        @(negedge PCLK);
        PRESETn = 1'b1;
        for (int i = 0; i < 3; i++) begin
            model_regs[i] = '0;
        end
    endtask

    // One APB transfer that starts and ends on a falling edge
    task automatic apb_xfer(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, output apb_rsp_t rsp);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = write ? wdata : '0;
        @(negedge PCLK);
        apb_req.penable = 1'b1;
        // The access phase ends at the first rising edge that sees PREADY high
        while (!apb_rsp.pready) @(negedge PCLK);
        rsp = apb_rsp;
        @(negedge PCLK);
        apb_req = '0;
    endtask

    task automatic check_rsp(input string name, input apb_rsp_t got, input apb_rsp_t exp);
        checks++;
        if (got.prdata !== exp.prdata) begin
            errors++;
            $display("Fail at %0t ns: %s prdata got %h expected %h",
                     $time, name, got.prdata, exp.prdata);
        end
        if (got.pslverr !== exp.pslverr) begin
            errors++;
            $display("Fail at %0t ns: %s pslverr got %b expected %b",
                     $time, name, got.pslverr, exp.pslverr);
        end
    endtask

    task automatic check_pwm(input string name, input logic [`PWM_CNT_W-1:0] got,
                             input logic [`PWM_CNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
        apb_rsp_t rsp;
        apb_xfer(1'b1, addr, data, rsp);
        // Writes to the ID word or outside the map leave the model alone
        case (addr)
            `PWM_OFS_CTRL:   model_regs[0] = data;
            `PWM_OFS_PERIOD: model_regs[1] = data;
            `PWM_OFS_DUTY:   model_regs[2] = data;
            default: ;
        endcase
    endtask

    task automatic read_check(input string name, input logic [31:0] addr);
        apb_rsp_t got;
        apb_rsp_t exp;
        exp        = '0;
        exp.pready = 1'b1;
        exp.prdata = expected_word(addr);
        apb_xfer(1'b0, addr, '0, got);
        check_rsp(name, got, exp);
    endtask

    task automatic end_test(input int num, input string title);
        $display("[test %0d] %s: %0d errors", num, title, errors - test_base);
        test_base = errors;
    endtask

    // Skips one period_start pulse, then counts cycles at the given level
    // over the whole period that opens with the next pulse
    task automatic measure_period(input logic level, output logic [`PWM_CNT_W-1:0] count);
        while (!period_start) @(negedge PCLK);
        @(negedge PCLK);
        while (!period_start) @(negedge PCLK);
        count = '0;
        do begin
            if (pwm_out == level) count++;
            @(negedge PCLK);
        end while (!period_start);
    endtask

    task automatic count_idle(output logic [`PWM_CNT_W-1:0] starts,
                              output logic [`PWM_CNT_W-1:0] highs);
        starts = '0;
        highs  = '0;
        repeat (50) begin
            if (period_start) starts++;
            if (pwm_out) highs++;
            @(negedge PCLK);
        end
    endtask

    task automatic test_readback();
        int          idx;
        logic [31:0] addr;
        for (int i = 0; i < 40; i++) begin
            idx  = int'(rand_bits(2) % 3);
            addr = 32'(idx * 4);
            reg_write(addr, rand_bits(32));
            read_check("register readback", addr);
        end
    endtask

    task automatic test_const();
        logic [31:0] upper;
        logic [31:0] sel;
        logic [31:0] addr;
        read_check("ID word", `PWM_OFS_ID);
        reg_write(`PWM_OFS_ID, rand_bits(32));
        read_check("ID word after write", `PWM_OFS_ID);
        for (int i = 0; i < 6; i++) begin
            // Setting at least one address bit above bit 3 makes the word unmapped
            upper = rand_bits(28);
            if (upper == '0) upper = 32'h1;
            sel  = rand_bits(2);
            addr = {upper[27:0], sel[1:0], 2'b00};
            reg_write(addr, rand_bits(32));
            read_check("unmapped read", addr);
        end
        read_check("CTRL after stray writes", `PWM_OFS_CTRL);
        read_check("PERIOD after stray writes", `PWM_OFS_PERIOD);
        read_check("DUTY after stray writes", `PWM_OFS_DUTY);
    endtask

    task automatic run_duty(input logic inv);
        int                    period;
        int                    duty;
        logic [`PWM_CNT_W-1:0] count;
        logic [`PWM_CNT_W-1:0] exp_count;
        for (int i = 0; i < 8; i++) begin
            period = 2 + int'(rand_bits(6) % 39);
            duty   = int'(rand_bits(6) % (period + 6));
            // Settings go in while disabled, then enable picks them up
            reg_write(`PWM_OFS_CTRL, {30'h0, inv, 1'b0});
            reg_write(`PWM_OFS_PERIOD, 32'(period));
            reg_write(`PWM_OFS_DUTY, 32'(duty));
            reg_write(`PWM_OFS_CTRL, {30'h0, inv, 1'b1});
            measure_period(!inv, count);
            exp_count = `PWM_CNT_W'((duty < period) ? duty : period);
            check_pwm(inv ? "pwm_out low cycles" : "pwm_out high cycles", count, exp_count);
        end
    endtask

    task automatic test_idle();
        logic [`PWM_CNT_W-1:0] starts;
        logic [`PWM_CNT_W-1:0] highs;
        // Disabled with invert set, so the idle level is high
        reg_write(`PWM_OFS_CTRL, 32'h2);
        count_idle(starts, highs);
        check_pwm("period_start pulses while disabled", starts, '0);
        check_pwm("pwm_out high cycles while disabled", highs, `PWM_CNT_W'(50));
        apply_reset();
        checks++;
        if (apb_rsp.pready !== 1'b1) begin
            errors++;
            $display("Fail at %0t ns: pready after reset got %b expected %b",
                     $time, apb_rsp.pready, 1'b1);
        end
        count_idle(starts, highs);
        check_pwm("period_start pulses after reset", starts, '0);
        check_pwm("pwm_out high cycles after reset", highs, '0);
        read_check("CTRL after reset", `PWM_OFS_CTRL);
    endtask

    initial begin
        int assert_fails;
        PRESETn    = 1'b0;
        apb_req    = '0;
        lfsr_state = 32'h3371_906e;
        checks     = 0;
        errors     = 0;
        test_base  = 0;
        apply_reset();
        test_readback();
        end_test(1, "register readback");
        test_const();
        end_test(2, "constant and unmapped addresses");
        run_duty(1'b0);
        end_test(3, "duty ratio");
        run_duty(1'b1);
        end_test(4, "inverted duty ratio");
        test_idle();
        end_test(5, "disable and reset state");
        // Protocol assertions in the bridge count their own failures
        assert_fails = uut.u_bridge.u_assert.fail_count;
        errors = errors + assert_fails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verilog
verilog/pwm_pkg.sv
verilog/apb_sb_bridge.sv
verilog/pwm_regs.sv
verilog/pwm_generator.sv
verilog/pwm_apb_top.sv
verification/pwm_apb_assert.sv
verification/tb_pwm_apb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the PWM APB testbench with Verilator and runs it.
# The run passes only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pwm_apb -f sim.f \
    -Mdir obj_dir -o vsim_pwm_apb \
    || { echo "Verilator build failed"; exit 1; }

# Let assertion errors be counted instead of stopping the run early
output=$(./obj_dir/vsim_pwm_apb +verilator+error+limit+1000 2>&1)
echo "$output"

echo "$output" | grep -qx "Test OK" && exit 0 || exit 1
